/* Makefile */
# Verilator build and run of the execution core testbench

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }
	@echo "test done, pass line found in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
hdl/ooo_pkg.sv
hdl/inst_decode.sv
hdl/operand_fetch.sv
hdl/reorder_buffer.sv
hdl/reservation_station.sv
hdl/alu_stage.sv
hdl/ooo_core.sv
verif/ooo_core_tb.sv

/* hdl/alu_stage.sv */
//////////////////////////////
// single ALU, result registered onto the bus
//////////////////////////////

`timescale 1ns/1ps

module alu_stage import ooo_pkg::*; (
	input  logic      clock,
	input  logic      arst_n,
	input  rs_entry_t issue,
	output cdb_t      cdb
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] result;
	logic            valid_q;
	rob_tag_t        tag_q;
	logic [XLEN-1:0] value_q;

	assign op_a = issue.src[0].value;
	assign op_b = issue.src[1].value;

	always_comb begin
		case (issue.op)
			ALU_ADD:  result = op_a + op_b;
			ALU_SUB:  result = op_a - op_b;
			ALU_AND:  result = op_a & op_b;
			ALU_OR:   result = op_a | op_b;
			ALU_XOR:  result = op_a ^ op_b;
			// compares give 0 or 1
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
			default:  result = '0;
		endcase
	end

	// bus valid for exactly one cycle per issue
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue.valid;
		end
	end

	always_ff @(posedge clock) begin
		tag_q   <= issue.dest;
		value_q <= result;
	end

	assign cdb = '{valid: valid_q, tag: tag_q, value: value_q};

endmodule

/* hdl/inst_decode.sv */
//////////////////////////////
// instruction decoder for the ALU subset and WFI
//////////////////////////////

`timescale 1ns/1ps

module inst_decode import ooo_pkg::*; (
	input  inst_word_u    inst_word,
	output decoded_inst_t dec
);

	always_comb begin
		dec         = '0;
		dec.op      = ALU_ADD;
		// sign-extended I immediate
		dec.imm     = {{(XLEN-12){inst_word.i.imm12[11]}}, inst_word.i.imm12};
		dec.rs1     = inst_word.r.rs1;
		dec.rs2     = inst_word.r.rs2;
		dec.rd      = inst_word.r.rd;
		case (inst_word.r.opcode)
			// register-register group
			OPC_OP: begin
				dec.needs_alu = 1'b1;
				case ({inst_word.r.funct7, inst_word.r.funct3})
					{7'h00, 3'b000}: dec.op = ALU_ADD;
					{7'h20, 3'b000}: dec.op = ALU_SUB;
					{7'h00, 3'b111}: dec.op = ALU_AND;
					{7'h00, 3'b110}: dec.op = ALU_OR;
					{7'h00, 3'b100}: dec.op = ALU_XOR;
					{7'h00, 3'b010}: dec.op = ALU_SLT;
					{7'h00, 3'b011}: dec.op = ALU_SLTU;
					default:         dec.illegal = 1'b1;
				endcase
			end
			// immediate group, shifts are not supported
			OPC_OP_IMM: begin
				dec.needs_alu = 1'b1;
				dec.use_imm   = 1'b1;
				case (inst_word.i.funct3)
					3'b000:  dec.op = ALU_ADD;
					3'b010:  dec.op = ALU_SLT;
					3'b011:  dec.op = ALU_SLTU;
					3'b100:  dec.op = ALU_XOR;
					3'b110:  dec.op = ALU_OR;
					3'b111:  dec.op = ALU_AND;
					default: dec.illegal = 1'b1;
				endcase
			end
			default: begin
				if (inst_word == WFI_WORD) begin
					dec.is_wfi = 1'b1;
				end else begin
					dec.illegal = 1'b1;
				end
			end
		endcase
		// illegal words never reach the ALU
		if (dec.illegal) begin
			dec.needs_alu = 1'b0;
		end
		dec.rd_write = dec.needs_alu && (dec.rd != '0);
	end

endmodule

/* hdl/ooo_core.sv */
//////////////////////////////
// top level of the execution core
//////////////////////////////

`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; #(
	parameter int ROB_DEPTH = 8,
	parameter int RS_DEPTH  = 4
) (
	input  logic         clock,
	input  logic         arst_n,
	input  logic         inst_valid,
	input  inst_word_u   inst_word,
	output logic         inst_ready,
	output commit_t      commit,
	output core_status_e status
);

	decoded_inst_t        dec;
	rob_tag_t             alloc_tag;
	rob_tag_t [1:0]       src_tag;
	logic [1:0]           rob_src_done;
	logic [1:0][XLEN-1:0] rob_src_value;
	rs_entry_t            new_entry;
	rs_entry_t            issue;
	logic                 rs_full;
	cdb_t                 cdb;

	// decode
	inst_decode i_inst_decode (
		.inst_word (inst_word),
		.dec       (dec)
	);

	// rename and operands
	operand_fetch i_operand_fetch (
		.clock         (clock),
		.arst_n        (arst_n),
		.dec           (dec),
		.accept_valid  (inst_valid),
		.accept_ready  (inst_ready),
		.alloc_tag     (alloc_tag),
		.rob_src_done  (rob_src_done),
		.rob_src_value (rob_src_value),
		.cdb           (cdb),
		.commit        (commit),
		.src_tag       (src_tag),
		.new_entry     (new_entry)
	);

	reorder_buffer #(
		.ROB_DEPTH (ROB_DEPTH)
	) i_reorder_buffer (
		.clock         (clock),
		.arst_n        (arst_n),
		.inst_valid    (inst_valid),
		.dec           (dec),
		.rs_full       (rs_full),
		.src_tag       (src_tag),
		.cdb           (cdb),
		.inst_ready    (inst_ready),
		.alloc_tag     (alloc_tag),
		.rob_src_done  (rob_src_done),
		.rob_src_value (rob_src_value),
		.commit        (commit),
		.status        (status)
	);

	reservation_station #(
		.RS_DEPTH (RS_DEPTH)
	) i_reservation_station (
		.clock      (clock),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst_ready (inst_ready),
		.new_entry  (new_entry),
		.cdb        (cdb),
		.rs_full    (rs_full),
		.issue      (issue)
	);

	// execute, drives the result bus
	alu_stage i_alu_stage (
		.clock  (clock),
		.arst_n (arst_n),
		.issue  (issue),
		.cdb    (cdb)
	);

endmodule

/* hdl/ooo_pkg.sv */
//////////////////////////////
// widths, instruction views, bus records
// and status codes of the core
//////////////////////////////

package ooo_pkg;

	// data and instruction width
	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	// covers ROB_DEPTH up to 16
	localparam int TAG_W     = 4;

	// opcodes of the accepted subset
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [XLEN-1:0] WFI_WORD = 32'h1050_0073;

	typedef logic [TAG_W-1:0] rob_tag_t;

	//////////////////////////////
	// instruction word, two decodings
	typedef struct packed {
		logic [6:0]           funct7;
		logic [REG_IDX_W-1:0] rs2;
		logic [REG_IDX_W-1:0] rs1;
		logic [2:0]           funct3;
		logic [REG_IDX_W-1:0] rd;
		logic [6:0]           opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0]          imm12;
		logic [REG_IDX_W-1:0] rs1;
		logic [2:0]           funct3;
		logic [REG_IDX_W-1:0] rd;
		logic [6:0]           opcode;
	} i_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
	} inst_word_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	//////////////////////////////
	// records passed between blocks
	typedef struct packed {
		alu_op_e              op;
		logic [REG_IDX_W-1:0] rs1;
		logic [REG_IDX_W-1:0] rs2;
		logic                 use_imm;
		logic [XLEN-1:0]      imm;
		logic [REG_IDX_W-1:0] rd;
		// rd nonzero and written
		logic                 rd_write;
		logic                 needs_alu;
		logic                 is_wfi;
		logic                 illegal;
	} decoded_inst_t;

	// one source operand, value valid once ready
	typedef struct packed {
		logic            ready;
		rob_tag_t        tag;
		logic [XLEN-1:0] value;
	} operand_t;

	typedef struct packed {
		alu_op_e        op;
		operand_t [1:0] src;
		rob_tag_t       dest;
		logic           valid;
	} rs_entry_t;

	// result bus
	typedef struct packed {
		logic            valid;
		rob_tag_t        tag;
		logic [XLEN-1:0] value;
	} cdb_t;

	typedef struct packed {
		logic                 valid;
		logic [REG_IDX_W-1:0] rd;
		logic                 wr_en;
		logic [XLEN-1:0]      data;
	} commit_t;

	typedef enum logic [1:0] {
		NO_ERROR,
		HALTED_ON_WFI,
		ILLEGAL_INST
	} core_status_e;

endpackage

/* hdl/operand_fetch.sv */
//////////////////////////////
// architectural registers, rename map
// and source operand resolution
//////////////////////////////

`timescale 1ns/1ps

module operand_fetch import ooo_pkg::*; (
	input  logic                  clock,
	input  logic                  arst_n,
	input  decoded_inst_t         dec,
	input  logic                  accept_valid,
	input  logic                  accept_ready,
	input  rob_tag_t              alloc_tag,
	input  logic [1:0]            rob_src_done,
	input  logic [1:0][XLEN-1:0]  rob_src_value,
	input  cdb_t                  cdb,
	input  commit_t               commit,
	output rob_tag_t [1:0]        src_tag,
	output rs_entry_t             new_entry
);

	logic [XLEN-1:0] arf [32];
	rob_tag_t        map_tag [32];
	logic [31:0]     pending;
	// tag of the ROB head, follows commits in order
	rob_tag_t        commit_tag;
	logic [1:0][REG_IDX_W-1:0] src_idx;
	logic            accept;

	assign accept     = accept_valid && accept_ready;
	assign src_idx[0] = dec.rs1;
	assign src_idx[1] = dec.rs2;
	assign src_tag[0] = map_tag[dec.rs1];
	assign src_tag[1] = map_tag[dec.rs2];

	//////////////////////////////
	// operand pick: register file, then ROB, then bus
	always_comb begin
		new_entry.op    = dec.op;
		new_entry.dest  = alloc_tag;
		new_entry.valid = dec.needs_alu;
		for (int s = 0; s < 2; s++) begin
			new_entry.src[s].tag = src_tag[s];
			if (src_idx[s] == '0 || !pending[src_idx[s]]) begin
				new_entry.src[s].ready = 1'b1;
				new_entry.src[s].value = arf[src_idx[s]];
			end else if (rob_src_done[s]) begin
				new_entry.src[s].ready = 1'b1;
				new_entry.src[s].value = rob_src_value[s];
			end else if (cdb.valid && cdb.tag == src_tag[s]) begin
				// producer broadcasting right now
				new_entry.src[s].ready = 1'b1;
				new_entry.src[s].value = cdb.value;
			end else begin
				new_entry.src[s].ready = 1'b0;
				new_entry.src[s].value = '0;
			end
		end
		// immediate replaces rs2
		if (dec.use_imm) begin
			new_entry.src[1].ready = 1'b1;
			new_entry.src[1].value = dec.imm;
		end
	end

	//////////////////////////////
	// commit writes, then renaming at acceptance
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pending    <= '0;
			commit_tag <= '0;
			for (int i = 0; i < 32; i++) begin
				arf[i]     <= '0;
				map_tag[i] <= '0;
			end
		end else begin
			if (commit.valid) begin
				commit_tag <= commit_tag + rob_tag_t'(1);
				if (commit.wr_en) begin
					arf[commit.rd] <= commit.data;
					// only the youngest writer clears the pending bit
					if (map_tag[commit.rd] == commit_tag) begin
						pending[commit.rd] <= 1'b0;
					end
				end
			end
			// a rename at the same edge wins
			if (accept && dec.rd_write) begin
				pending[dec.rd] <= 1'b1;
				map_tag[dec.rd] <= alloc_tag;
			end
		end
	end

endmodule

/* hdl/reorder_buffer.sv */
//////////////////////////////
// circular reorder buffer with in-order
// commit, dispatch gating and core status
//////////////////////////////

`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; #(
	parameter int ROB_DEPTH = 8
) (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 inst_valid,
	input  decoded_inst_t        dec,
	input  logic                 rs_full,
	input  rob_tag_t [1:0]       src_tag,
	input  cdb_t                 cdb,
	output logic                 inst_ready,
	output rob_tag_t             alloc_tag,
	output logic [1:0]           rob_src_done,
	output logic [1:0][XLEN-1:0] rob_src_value,
	output commit_t              commit,
	output core_status_e         status
);

	localparam int IDX_W = $clog2(ROB_DEPTH);

	// entry fields
	logic [REG_IDX_W-1:0] ent_rd [ROB_DEPTH];
	logic [XLEN-1:0]      ent_value [ROB_DEPTH];
	core_status_e         ent_kind [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] ent_wr_en;
	logic [ROB_DEPTH-1:0] ent_done;

	// head and tail run over the full tag range, low bits index
	rob_tag_t        head;
	rob_tag_t        tail;
	logic [TAG_W:0]  count;
	logic            stop;
	logic            up;
	logic            accept;
	logic [IDX_W-1:0] head_idx;
	logic [IDX_W-1:0] tail_idx;

	assign head_idx   = head[IDX_W-1:0];
	assign tail_idx   = tail[IDX_W-1:0];
	assign alloc_tag  = tail;
	assign inst_ready = up && !stop && !rs_full && (count != (TAG_W+1)'(ROB_DEPTH));
	assign accept     = inst_valid && inst_ready;

	// source lookups
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			rob_src_done[s]  = ent_done[src_tag[s][IDX_W-1:0]];
			rob_src_value[s] = ent_value[src_tag[s][IDX_W-1:0]];
		end
	end

	// head retires while done
	always_comb begin
		commit.valid = (count != '0) && ent_done[head_idx];
		commit.rd    = ent_rd[head_idx];
		commit.wr_en = commit.valid && ent_wr_en[head_idx];
		commit.data  = ent_value[head_idx];
	end

	//////////////////////////////
	// control state
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head     <= '0;
			tail     <= '0;
			count    <= '0;
			stop     <= 1'b0;
			up       <= 1'b0;
			ent_done <= '0;
			status   <= NO_ERROR;
		end else begin
			up    <= 1'b1;
			count <= count + {{TAG_W{1'b0}}, accept} - {{TAG_W{1'b0}}, commit.valid};
			if (cdb.valid) begin
				ent_done[cdb.tag[IDX_W-1:0]] <= 1'b1;
			end
			if (accept) begin
				tail <= tail + rob_tag_t'(1);
				// WFI and illegal words need no execution
				ent_done[tail_idx] <= !dec.needs_alu;
				if (dec.is_wfi || dec.illegal) begin
					stop <= 1'b1;
				end
			end
			if (commit.valid) begin
				head <= head + rob_tag_t'(1);
				if (status == NO_ERROR) begin
					status <= ent_kind[head_idx];
				end
			end
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		if (cdb.valid) begin
			ent_value[cdb.tag[IDX_W-1:0]] <= cdb.value;
		end
		if (accept) begin
			ent_rd[tail_idx]    <= dec.rd;
			ent_wr_en[tail_idx] <= dec.rd_write;
			ent_value[tail_idx] <= '0;
			ent_kind[tail_idx]  <= dec.is_wfi ? HALTED_ON_WFI :
				dec.illegal ? ILLEGAL_INST : NO_ERROR;
		end
	end

endmodule

/* hdl/reservation_station.sv */
//////////////////////////////
// reservation station with bus wakeup
// and lowest-index ready issue
//////////////////////////////

`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; #(
	parameter int RS_DEPTH = 4
) (
	input  logic      clock,
	input  logic      arst_n,
	input  logic      inst_valid,
	input  logic      inst_ready,
	input  rs_entry_t new_entry,
	input  cdb_t      cdb,
	output logic      rs_full,
	output rs_entry_t issue
);

	localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

	rs_entry_t        slots [RS_DEPTH];
	logic             load;
	logic             free_found;
	logic [IDX_W-1:0] free_idx;
	logic             sel_found;
	logic [IDX_W-1:0] sel_idx;

	// capture a broadcast value into waiting operands
	function automatic rs_entry_t wake_entry(input rs_entry_t e, input cdb_t b);
		rs_entry_t r;
		r = e;
		for (int s = 0; s < 2; s++) begin
			if (b.valid && !r.src[s].ready && r.src[s].tag == b.tag) begin
				r.src[s].ready = 1'b1;
				r.src[s].value = b.value;
			end
		end
		return r;
	endfunction

	// only ALU work enters
	assign load = inst_valid && inst_ready && new_entry.valid;

	//////////////////////////////
	// free slot and issue pick, lowest index wins
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		sel_found  = 1'b0;
		sel_idx    = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!slots[i].valid) begin
				free_found = 1'b1;
				free_idx   = IDX_W'(i);
			end
			if (slots[i].valid && slots[i].src[0].ready && slots[i].src[1].ready) begin
				sel_found = 1'b1;
				sel_idx   = IDX_W'(i);
			end
		end
	end

	assign rs_full = !free_found;

	always_comb begin
		issue       = slots[sel_idx];
		issue.valid = sel_found;
	end

	//////////////////////////////
	// slot update
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				slots[i].valid <= 1'b0;
			end
		end else begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				if (sel_found && sel_idx == IDX_W'(i)) begin
					// issued this cycle
					slots[i].valid <= 1'b0;
				end else if (load && free_idx == IDX_W'(i)) begin
					// new entry also sees this cycle's broadcast
					slots[i] <= wake_entry(new_entry, cdb);
				end else if (slots[i].valid) begin
					slots[i] <= wake_entry(slots[i], cdb);
				end
			end
		end
	end

endmodule

/* verif/ooo_core_tb.sv */
//////////////////////////////
// testbench for the execution core
// LCG stimulus, in-order register model, commit checks
//////////////////////////////

`timescale 1ns/1ps

module ooo_core_tb import ooo_pkg::*; ();

	localparam int ROB_DEPTH = 8;
	localparam int RS_DEPTH  = 4;
	localparam int N_RANDOM  = 300;
	localparam int N_CHAIN   = 100;
	localparam int N_SHORT   = 20;
	// two halting words on top of the streams
	localparam int N_INSTR   = N_RANDOM + N_CHAIN + N_SHORT + 2;
	localparam int TIMEOUT_CYCLES = N_INSTR * (ROB_DEPTH + 4) + 200;

	// RV32I opcodes
	localparam logic [6:0] RV_OP     = 7'b0110011;
	localparam logic [6:0] RV_OP_IMM = 7'b0010011;

	// instruction kinds of the stimulus
	localparam logic [3:0] K_ADD = 4'd0, K_SUB = 4'd1, K_AND = 4'd2, K_OR = 4'd3;
	localparam logic [3:0] K_XOR = 4'd4, K_SLT = 4'd5, K_SLTU = 4'd6, K_ADDI = 4'd7;
	localparam logic [3:0] K_SLTI = 4'd8, K_SLTIU = 4'd9, K_XORI = 4'd10, K_ORI = 4'd11;
	localparam logic [3:0] K_ANDI = 4'd12, K_WFI = 4'd13, K_ILLEGAL = 4'd14;

	typedef struct packed {
		logic [3:0]  kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
	} stim_t;

	// one expected commit
	typedef struct packed {
		logic        halt;
		logic [4:0]  rd;
		logic        wr_en;
		logic [31:0] data;
	} expect_t;

	logic         clock;
	logic         arst_n;
	logic         inst_valid;
	inst_word_u   inst_word;
	logic         inst_ready;
	commit_t      commit;
	core_status_e status;

	logic [31:0]  model_rf [32];
	expect_t      expect_q [$];
	logic [31:0]  rng_state;
	int           errors;
	int           commits;
	int           stalls;
	int           cycle_count;
	string        test_name;
	// halting word accepted, then retired
	logic         stopped;
	logic         halt_seen;
	core_status_e halt_status;

	ooo_core #(
		.ROB_DEPTH (ROB_DEPTH),
		.RS_DEPTH  (RS_DEPTH)
	) i_ooo_core (
		.clock      (clock),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst_word  (inst_word),
		.inst_ready (inst_ready),
		.commit     (commit),
		.status     (status)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////
	// random numbers and encoding
	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		// upper bits of the LCG are the better ones
		return (lcg_next() >> 8) % n;
	endfunction

	// mostly x0..x3 so that dependencies are frequent
	function automatic logic [4:0] pick_reg();
		if (rand_below(4) != 0) begin
			return 5'(rand_below(4));
		end
		return 5'(rand_below(32));
	endfunction

	function automatic logic [31:0] encode_inst(input stim_t s);
		logic [31:0] w;
		case (s.kind)
			K_ADD:   w = {7'h00, s.rs2, s.rs1, 3'b000, s.rd, RV_OP};
			K_SUB:   w = {7'h20, s.rs2, s.rs1, 3'b000, s.rd, RV_OP};
			K_AND:   w = {7'h00, s.rs2, s.rs1, 3'b111, s.rd, RV_OP};
			K_OR:    w = {7'h00, s.rs2, s.rs1, 3'b110, s.rd, RV_OP};
			K_XOR:   w = {7'h00, s.rs2, s.rs1, 3'b100, s.rd, RV_OP};
			K_SLT:   w = {7'h00, s.rs2, s.rs1, 3'b010, s.rd, RV_OP};
			K_SLTU:  w = {7'h00, s.rs2, s.rs1, 3'b011, s.rd, RV_OP};
			K_ADDI:  w = {s.imm, s.rs1, 3'b000, s.rd, RV_OP_IMM};
			K_SLTI:  w = {s.imm, s.rs1, 3'b010, s.rd, RV_OP_IMM};
			K_SLTIU: w = {s.imm, s.rs1, 3'b011, s.rd, RV_OP_IMM};
			K_XORI:  w = {s.imm, s.rs1, 3'b100, s.rd, RV_OP_IMM};
			K_ORI:   w = {s.imm, s.rs1, 3'b110, s.rd, RV_OP_IMM};
			K_ANDI:  w = {s.imm, s.rs1, 3'b111, s.rd, RV_OP_IMM};
			K_WFI:   w = 32'h1050_0073;
			// all-zero word is not a valid RV32I instruction
			default: w = 32'h0000_0000;
		endcase
		return w;
	endfunction

	//////////////////////////////
	// in-order reference model
	function automatic expect_t execute_model(input stim_t s);
		expect_t     e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		e   = '0;
		imm = {{20{s.imm[11]}}, s.imm};
		a   = model_rf[s.rs1];
		b   = (s.kind >= K_ADDI) ? imm : model_rf[s.rs2];
		case (s.kind)
			K_ADD, K_ADDI:   e.data = a + b;
			K_SUB:           e.data = a - b;
			K_AND, K_ANDI:   e.data = a & b;
			K_OR, K_ORI:     e.data = a | b;
			K_XOR, K_XORI:   e.data = a ^ b;
			K_SLT, K_SLTI:   e.data = {31'b0, $signed(a) < $signed(b)};
			// sltiu compares against the sign-extended immediate
			K_SLTU, K_SLTIU: e.data = {31'b0, a < b};
			default:         e.halt = 1'b1;
		endcase
		if (!e.halt) begin
			e.rd    = s.rd;
			e.wr_en = (s.rd != 5'd0);
			if (e.wr_en) begin
				model_rf[s.rd] = e.data;
			end
		end
		return e;
	endfunction

	task automatic check_value(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s, %s: expected %h, actual %h", test_name, field, expected, actual);
		end
	endtask

	//////////////////////////////
	// per-cycle monitor, sampled at the falling edge
	task automatic next_cycle();
		expect_t      e;
		core_status_e want;
		@(negedge clock);
		want = halt_seen ? halt_status : NO_ERROR;
		check_value("status", 32'(want), 32'(status));
		if (stopped) begin
			check_value("inst_ready after halt", 32'd0, 32'(inst_ready));
		end
		if (commit.valid) begin
			if (expect_q.size() == 0) begin
				errors++;
				$display("%s: the core committed an instruction that was not outstanding",
					test_name);
			end else begin
				e = expect_q.pop_front();
				commits++;
				check_value("commit wr_en", 32'(e.wr_en), 32'(commit.wr_en));
				if (e.halt) begin
					halt_seen = 1'b1;
				end else begin
					check_value("commit rd", 32'(e.rd), 32'(commit.rd));
					check_value("commit data", e.data, commit.data);
				end
			end
		end
		// ROB occupancy bound
		if (expect_q.size() > ROB_DEPTH) begin
			errors++;
			$display("%s: more than %0d instructions in flight", test_name, ROB_DEPTH);
		end
	endtask

	// holds the word until the core takes it
	task automatic issue_word(input stim_t s);
		logic    accepted;
		expect_t e;
		accepted   = 1'b0;
		inst_valid = 1'b1;
		inst_word  = encode_inst(s);
		while (!accepted) begin
			// ready does not depend on valid, already settled here
			if (inst_ready) begin
				e = execute_model(s);
				expect_q.push_back(e);
				accepted = 1'b1;
				if (e.halt) begin
					stopped     = 1'b1;
					halt_status = (s.kind == K_WFI) ? HALTED_ON_WFI : ILLEGAL_INST;
				end
			end else begin
				stalls++;
			end
			next_cycle();
		end
	endtask

	task automatic apply_reset();
		inst_valid = 1'b0;
		arst_n     = 1'b0;
		stopped    = 1'b0;
		halt_seen  = 1'b0;
		expect_q.delete();
		for (int i = 0; i < 32; i++) begin
			model_rf[i] = '0;
		end
		repeat (5) begin
			next_cycle();
			check_value("inst_ready in reset", 32'd0, 32'(inst_ready));
			check_value("commit valid in reset", 32'd0, 32'(commit.valid));
			check_value("bus valid in reset", 32'd0, 32'(i_ooo_core.cdb.valid));
		end
		arst_n = 1'b1;
		next_cycle();
		check_value("inst_ready after reset", 32'd1, 32'(inst_ready));
	endtask

	//////////////////////////////
	// stimulus phases
	task automatic run_random(input int n);
		stim_t s;
		for (int i = 0; i < n; i++) begin
			s.kind = 4'(rand_below(13));
			s.rd   = pick_reg();
			s.rs1  = pick_reg();
			s.rs2  = pick_reg();
			s.imm  = 12'(lcg_next() >> 20);
			issue_word(s);
			// idle gap now and then
			if (rand_below(4) == 0) begin
				inst_valid = 1'b0;
				repeat (1 + rand_below(3)) next_cycle();
			end
		end
	endtask

	// x1..x3 only, back to back
	task automatic run_chain(input int n);
		stim_t s;
		for (int i = 0; i < n; i++) begin
			s.kind = 4'(rand_below(13));
			s.rd   = 5'(1 + rand_below(3));
			s.rs1  = 5'(1 + rand_below(3));
			s.rs2  = 5'(1 + rand_below(3));
			s.imm  = 12'(lcg_next() >> 20);
			issue_word(s);
		end
	endtask

	task automatic halt_core(input logic [3:0] kind);
		stim_t s;
		s      = '0;
		s.kind = kind;
		issue_word(s);
		inst_valid = 1'b0;
		// drain, the halting commit comes last
		while (expect_q.size() != 0) begin
			next_cycle();
		end
		next_cycle();
		check_value("final status", 32'(halt_status), 32'(status));
		// quiet period, no commit and no ready
		repeat (20) next_cycle();
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial begin
		rng_state   = 32'h5f35534c;
		errors      = 0;
		commits     = 0;
		stalls      = 0;
		arst_n      = 1'b0;
		inst_valid  = 1'b0;
		inst_word   = '0;
		halt_status = NO_ERROR;
		test_name   = "reset";
		apply_reset();
		test_name = "random alu stream";
		run_random(N_RANDOM);
		test_name = "dependency chains";
		run_chain(N_CHAIN);
		test_name = "wfi halt";
		halt_core(K_WFI);
		// second run ends on an undefined word
		test_name = "reset";
		apply_reset();
		test_name = "illegal instruction";
		run_random(N_SHORT);
		halt_core(K_ILLEGAL);
		$display("errors: %0d, commits checked: %0d, stalled cycles: %0d",
			errors, commits, stalls);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
